// File: dv/rf_pg_subsystem_sva.sv
// Bound checks on power sequencing
// Isolation order, output clamp and wake path

module rf_pg_subsystem_sva #(
     parameter bit check_rdata = 1'b1
    ,parameter bit check_state = 1'b1
) (
     input logic                              clk
    ,input logic                              rst
    ,input logic                              isol_en
    ,input logic                              enable_b
    ,input logic [rf_pg_pkg::rf_phys_w-1:0]   rdata
    ,input rf_pg_pkg::pg_state_t              state
);

    // Switches may only be off behind a raised clamp
    isol_covers_enable: assert property (
        @(posedge clk) disable iff (rst) enable_b |-> isol_en
    ) else $error("Switch enable is high while isolation is low");

    generate
        if (check_rdata) begin : rdata_chk
            // The clamp forces the array output to zero
            // The registered data must also be cleared by the time isolation drops
            rdata_clamped: assert property (
                @(posedge clk) disable iff (rst)
                    (isol_en || $past(isol_en)) |-> (rdata == '0)
            ) else $error("rdata is not zero while isolation is high or just released");
        end

        if (check_state) begin : state_chk
            // Leaving asleep_st always passes through powering_on
            wake_through_power_on: assert property (
                @(posedge clk) disable iff (rst) (state == rf_pg_pkg::asleep_st) |=>
                    ((state == rf_pg_pkg::asleep_st) || (state == rf_pg_pkg::powering_on))
            ) else $error("Sequencer left asleep_st without going through powering_on");
        end
    endgenerate

endmodule

// The sequencer has no read data, so only the ordering checks apply here
bind rf_pg_ctrl rf_pg_subsystem_sva #(
     .check_rdata (1'b0)
    ,.check_state (1'b1)
) ctrl_sva_inst (
     .clk      (rclk)
    ,.rst      (rst)
    ,.isol_en  (pgcb_isol_en)
    ,.enable_b (pwr_enable_b_in)
    ,.rdata    ({rf_pg_pkg::rf_phys_w{1'b0}})
    ,.state    (state)
);

// The array has no sequencer state, so only the clamp and enable checks apply here
bind rf_pg_array rf_pg_subsystem_sva #(
     .check_rdata (1'b1)
    ,.check_state (1'b0)
) array_sva_inst (
     .clk      (rclk)
    ,.rst      (ip_reset)
    ,.isol_en  (isol_en)
    ,.enable_b (pwr_enable_b_in)
    ,.rdata    (rdata)
    ,.state    (rf_pg_pkg::awake)
);

// File: dv/rf_pg_subsystem_tb.sv
// Testbench for the power-gated register file subsystem
// Table-driven stimulus checked against a reference memory

module rf_pg_subsystem_tb;

    localparam int clk_period = 8;

    // Longest wait for asleep or mem_ready, in clock cycles
    localparam int poll_limit = 4 * rf_pg_pkg::pg_chain_len + 8;

    typedef enum logic [2:0] {op_write, op_read, op_hold, op_sleep, op_wake} op_t;

    logic clk;
    logic rst;
    logic we;
    logic re;
    logic sleep_req;
    logic [rf_pg_pkg::rf_addr_w-1:0] waddr;
    logic [rf_pg_pkg::rf_addr_w-1:0] raddr;
    logic [rf_pg_pkg::rf_data_w-1:0] wdata;
    logic [rf_pg_pkg::rf_data_w-1:0] rdata;
    logic mem_ready;
    logic asleep;

    // Stimulus table, one entry per step across the four queues
    op_t                             op_q[$];
    logic [rf_pg_pkg::rf_addr_w-1:0] addr_q[$];
    logic [rf_pg_pkg::rf_data_w-1:0] data_q[$];
    logic [rf_pg_pkg::rf_data_w-1:0] exp_q[$];

    // Reference memory, wiped whenever the array sleeps
    logic [rf_pg_pkg::rf_data_w-1:0] ref_mem [rf_pg_pkg::rf_depth];
    logic [rf_pg_pkg::rf_depth-1:0]  ref_valid;
    logic                            ref_sleeping;
    logic [rf_pg_pkg::rf_data_w-1:0] ref_last;

    integer seed;
    int     error_count;
    int     cur_step;
    logic   table_ready;

    rf_pg_subsystem rf_pg_subsystem_inst (
         .wclk      (clk)
        ,.we        (we)
        ,.waddr     (waddr)
        ,.wdata     (wdata)
        ,.rclk      (clk)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.rdata     (rdata)
        ,.rst       (rst)
        ,.sleep_req (sleep_req)
        ,.mem_ready (mem_ready)
        ,.asleep    (asleep)
    );

    // Both clock ports share this one source
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------------------------
    // Table construction and reference model
    // ------------------------------------------------

    function automatic logic [rf_pg_pkg::rf_data_w-1:0] rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[rf_pg_pkg::rf_data_w-1:0];
    endfunction

    // Appends one step and works out the read value the array must give
    function automatic void add_step(input op_t op, input logic [rf_pg_pkg::rf_addr_w-1:0] addr,
                                     input logic [rf_pg_pkg::rf_data_w-1:0] data);
        logic [rf_pg_pkg::rf_data_w-1:0] exp;
        exp = '0;
        case (op)
            op_write: begin
                // Writes to a sleeping array are lost
                if (!ref_sleeping) begin
                    ref_mem[addr]   = data;
                    ref_valid[addr] = 1'b1;
                end
            end
            op_read: begin
                if (!ref_sleeping && ref_valid[addr]) begin
                    exp = ref_mem[addr];
                end
                ref_last = exp;
            end
            op_hold: begin
                exp = ref_last;
            end
            op_sleep: begin
                ref_sleeping = 1'b1;
                ref_valid    = '0;
                ref_last     = '0;
            end
            op_wake: begin
                ref_sleeping = 1'b0;
                ref_last     = '0;
            end
            default: begin
            end
        endcase
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(exp);
    endfunction

    function automatic void build_table();
        int j;
        ref_valid    = '0;
        ref_sleeping = 1'b0;
        ref_last     = '0;
        // Nothing written yet, every entry reads zero
        for (int i = 0; i < rf_pg_pkg::rf_depth; i++) add_step(op_read, i[3:0], '0);
        for (int i = 0; i < rf_pg_pkg::rf_depth; i++) add_step(op_write, i[3:0], rand_word());
        for (int i = 0; i < rf_pg_pkg::rf_depth; i++) add_step(op_read, i[3:0], '0);
        // Read straight after a write to the same entry
        for (int i = 0; i < 4; i++) begin
            j = 3 * i + 1;
            add_step(op_write, j[3:0], rand_word());
            add_step(op_read, j[3:0], '0);
        end
        // rdata keeps the old word until the overwritten entry is read again
        add_step(op_read, 4'd9, '0);
        add_step(op_hold, 4'd9, '0);
        add_step(op_write, 4'd9, rand_word());
        add_step(op_hold, 4'd9, '0);
        add_step(op_read, 4'd9, '0);
        add_step(op_hold, 4'd9, '0);
        // Accesses while asleep have no effect and read zero
        add_step(op_sleep, '0, '0);
        add_step(op_write, 4'd3, rand_word());
        add_step(op_write, 4'd4, rand_word());
        add_step(op_read, 4'd3, '0);
        add_step(op_hold, 4'd3, '0);
        add_step(op_wake, '0, '0);
        // Contents are gone after wake until rewritten
        for (int i = 0; i < rf_pg_pkg::rf_depth; i++) add_step(op_read, i[3:0], '0);
        for (int i = 0; i < 4; i++) add_step(op_write, i[3:0], rand_word());
        for (int i = 0; i < 4; i++) add_step(op_read, i[3:0], '0);
        add_step(op_sleep, '0, '0);
        add_step(op_wake, '0, '0);
        add_step(op_read, 4'd0, '0);
    endfunction

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------

    task automatic fail_now();
        error_count++;
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_data(input logic [rf_pg_pkg::rf_data_w-1:0] exp);
        assert (rdata === exp) else begin
            $display("ERROR: step %0d rdata = 0x%h, expected 0x%h", cur_step, rdata, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR: step %0d %s = 0x%h, expected 0x%h", cur_step, name, got, exp);
            fail_now();
        end
    endtask

    task automatic wait_ready(input string cause);
        int polls;
        polls = 0;
        while (!mem_ready && polls < poll_limit) begin
            @(negedge clk);
            polls++;
        end
        assert (mem_ready) else begin
            $display("Timeout: mem_ready did not rise after %s", cause);
            fail_now();
        end
    endtask

    // Applies one table entry, inputs change only on the falling edge
    task automatic run_step(input int idx);
        int polls;
        polls = 0;
        case (op_q[idx])
            op_write: begin
                we    = 1'b1;
                waddr = addr_q[idx];
                wdata = data_q[idx];
                @(negedge clk);
                we = 1'b0;
            end
            op_read: begin
                re    = 1'b1;
                raddr = addr_q[idx];
                @(negedge clk);
                re = 1'b0;
                check_data(exp_q[idx]);
            end
            op_hold: begin
                // A new address with re low must not disturb rdata
                raddr = ~raddr;
                repeat (3) @(negedge clk);
                check_data(exp_q[idx]);
            end
            op_sleep: begin
                sleep_req = 1'b1;
                @(negedge clk);
                check_bit("mem_ready", mem_ready, 1'b0);
                while (!asleep && polls < poll_limit) begin
                    @(negedge clk);
                    polls++;
                end
                assert (asleep) else begin
                    $display("Timeout: asleep did not rise after the sleep request");
                    fail_now();
                end
                check_data('0);
            end
            op_wake: begin
                sleep_req = 1'b0;
                wait_ready("the wake request");
                check_bit("asleep", asleep, 1'b0);
                check_data('0);
            end
            default: begin
            end
        endcase
    endtask

    // ------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------

    initial begin
        seed        = 58583;
        error_count = 0;
        cur_step    = -1;
        table_ready = 1'b0;
        rst         = 1'b1;
        we          = 1'b0;
        re          = 1'b0;
        sleep_req   = 1'b0;
        waddr       = '0;
        raddr       = '0;
        wdata       = '0;
        build_table();
        table_ready = 1'b1;

        repeat (4) @(negedge clk);
        check_bit("mem_ready", mem_ready, 1'b0);
        rst = 1'b0;
        wait_ready("reset");
        check_bit("asleep", asleep, 1'b0);
        check_data('0);

        for (int i = 0; i < op_q.size(); i++) begin
            cur_step = i;
            run_step(i);
        end

        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Budget is the reset wait plus the worst case of every step
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = (4 + poll_limit + op_q.size() * (poll_limit + 4)) * clk_period;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: hw/rf_pg_16x45.sv
// Logical 16x45 power-gated register file
// Pads the word to the physical array and syncs reset

module rf_pg_16x45 (
     input  logic                              wclk
    ,input  logic                              we
    ,input  logic [rf_pg_pkg::rf_addr_w-1:0]   waddr
    ,input  logic [rf_pg_pkg::rf_data_w-1:0]   wdata

    ,input  logic                              rclk
    ,input  logic                              re
    ,input  logic [rf_pg_pkg::rf_addr_w-1:0]   raddr
    ,output logic [rf_pg_pkg::rf_data_w-1:0]   rdata

    ,input  logic                              rst

    // Power interface
    ,input  logic                              pgcb_isol_en
    ,input  logic                              pwr_enable_b_in
    ,output logic                              pwr_enable_b_out

    // High once the array has left reset
    ,output logic                              rst_done
);

    // First stage of the reset synchronizer
    logic rst_meta;

    // Reset seen by the array, held two rclk cycles past rst
    logic ip_reset;

    // Words as the physical array sees them
    logic [rf_pg_pkg::rf_phys_w-1:0] wdata_phys;
    logic [rf_pg_pkg::rf_phys_w-1:0] rdata_phys;

    // -----------------------------------------------
    // Reset synchronizer
    // -----------------------------------------------

    // Assertion takes effect on the next rclk edge
    // Release walks through both flops before reaching the array
    always_ff @(posedge rclk) begin
        if (rst) begin
            rst_meta <= 1'b1;
            ip_reset <= 1'b1;
        end else begin
            rst_meta <= 1'b0;
            ip_reset <= rst_meta;
        end
    end

    assign rst_done = !ip_reset;

    // -----------------------------------------------
    // Data padding
    // -----------------------------------------------

    // The spare bit is written as zero
    assign wdata_phys = {1'b0, wdata};

    // and is dropped again on the way out
    assign rdata = rdata_phys[rf_pg_pkg::rf_data_w-1:0];

    // -----------------------------------------------
    // Physical array
    // -----------------------------------------------

    rf_pg_array rf_pg_array_inst (
         .wclk              (wclk)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata_phys)

        ,.rclk              (rclk)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata_phys)

        ,.ip_reset          (ip_reset)
        ,.isol_en           (pgcb_isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
    );

endmodule

// File: hw/rf_pg_array.sv
// Behavioral 16x46 two-port power-gated array
// Storage, switch chain, content loss and read isolation

module rf_pg_array (
     input  logic                              wclk
    ,input  logic                              we
    ,input  logic [rf_pg_pkg::rf_addr_w-1:0]   waddr
    ,input  logic [rf_pg_pkg::rf_phys_w-1:0]   wdata

    ,input  logic                              rclk
    ,input  logic                              re
    ,input  logic [rf_pg_pkg::rf_addr_w-1:0]   raddr
    ,output logic [rf_pg_pkg::rf_phys_w-1:0]   rdata

    ,input  logic                              ip_reset
    ,input  logic                              isol_en
    ,input  logic                              pwr_enable_b_in
    ,output logic                              pwr_enable_b_out
);

    // Word storage, contents are meaningless unless the valid bit is set
    logic [rf_pg_pkg::rf_phys_w-1:0] mem [rf_pg_pkg::rf_depth];

    // One bit per entry, set by a write and lost with power
    logic [rf_pg_pkg::rf_depth-1:0] valid;

    // Enable daisy chain, bit 0 is the segment nearest the input
    logic [rf_pg_pkg::pg_chain_len-1:0] pwr_chain;

    // High while any part of the array is switched off
    logic power_off;

    // Write qualified by power and reset
    logic wr_ok;

    // Registered read data before the isolation clamp
    logic [rf_pg_pkg::rf_phys_w-1:0] rdata_q;

    // -----------------------------------------------
    // Power switch chain
    // -----------------------------------------------

    // The enable ripples through one segment per rclk cycle
    // The last segment is returned so the sequencer can see completion
    assign pwr_enable_b_out = pwr_chain[rf_pg_pkg::pg_chain_len-1];

    always_ff @(posedge rclk) begin
        if (ip_reset) begin
            pwr_chain <= '0;
            power_off <= 1'b0;
        end else begin
            pwr_chain <= {pwr_chain[rf_pg_pkg::pg_chain_len-2:0], pwr_enable_b_in};
            // Power is lost as soon as the first segment starts to switch off
            if (pwr_enable_b_in) begin
                power_off <= 1'b1;
            end else if (!pwr_enable_b_out) begin
                // Power only returns once the far segment is back on
                power_off <= 1'b0;
            end
        end
    end

    // -----------------------------------------------
    // Write port
    // -----------------------------------------------

    // A write to an unpowered or resetting array is dropped
    assign wr_ok = we && !power_off && !ip_reset;

    // Losing power wipes every entry, modelled by clearing the valid bits
    // Both clocks come from one source so power_off is safe to use here
    always_ff @(posedge wclk) begin
        if (ip_reset || power_off) begin
            valid <= '0;
        end else if (wr_ok) begin
            valid[waddr] <= 1'b1;
        end
    end

    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem[waddr] <= wdata;
        end
    end

    // -----------------------------------------------
    // Read port
    // -----------------------------------------------

    // Read data is captured on re and held until the next read
    // An entry not written since power-up returns zero
    always_ff @(posedge rclk) begin
        if (ip_reset || isol_en) begin
            rdata_q <= '0;
        end else if (re) begin
            if (valid[raddr] && !power_off) begin
                rdata_q <= mem[raddr];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // Isolation clamps the output at once, even before the register clears
    assign rdata = isol_en ? '0 : rdata_q;

endmodule

// File: hw/rf_pg_ctrl.sv
// Power-gating sequencer
// Orders isolation and switch enable around a sleep request

module rf_pg_ctrl (
     input  logic                  rclk
    ,input  logic                  rst

    // Level request, high asks the array to power down
    ,input  logic                  sleep_req

    // Far end of the array switch chain
    ,input  logic                  pwr_enable_b_out

    ,output logic                  pgcb_isol_en
    ,output logic                  pwr_enable_b_in
    ,output logic                  asleep
    ,output logic                  awake

    // Current state, observed by the bound assertions
    ,output rf_pg_pkg::pg_state_t  state
);

    rf_pg_pkg::pg_state_t state_d;

    // -----------------------------------------------
    // Next state
    // -----------------------------------------------

    // Power down raises isolation first, then switches off
    // Power up switches on first, and drops isolation only afterwards
    always_comb begin
        state_d = state;
        case (state)
            rf_pg_pkg::awake: begin
                if (sleep_req) begin
                    state_d = rf_pg_pkg::isolating;
                end
            end
            rf_pg_pkg::isolating: begin
                // One cycle for the clamp to settle before any segment switches off
                state_d = rf_pg_pkg::powering_off;
            end
            rf_pg_pkg::powering_off: begin
                // Entry always completes, even if the request has already fallen
                if (pwr_enable_b_out) begin
                    state_d = rf_pg_pkg::asleep_st;
                end
            end
            rf_pg_pkg::asleep_st: begin
                if (!sleep_req) begin
                    state_d = rf_pg_pkg::powering_on;
                end
            end
            rf_pg_pkg::powering_on: begin
                // Wait until every segment of the chain is back on
                if (!pwr_enable_b_out) begin
                    state_d = rf_pg_pkg::awake;
                end
            end
            default: begin
                state_d = rf_pg_pkg::awake;
            end
        endcase
    end

    // -----------------------------------------------
    // State and output registers
    // -----------------------------------------------

    // Outputs are decoded from the next state and registered
    // so they change together with the state and never glitch
    always_ff @(posedge rclk) begin
        if (rst) begin
            state           <= rf_pg_pkg::awake;
            pgcb_isol_en    <= 1'b0;
            pwr_enable_b_in <= 1'b0;
            asleep          <= 1'b0;
            awake           <= 1'b1;
        end else begin
            state <= state_d;

            // Isolation covers every state but awake
            pgcb_isol_en <= (state_d != rf_pg_pkg::awake);

            // The switches are off only between powering_off and asleep_st
            pwr_enable_b_in <= (state_d == rf_pg_pkg::powering_off) ||
                               (state_d == rf_pg_pkg::asleep_st);

            asleep <= (state_d == rf_pg_pkg::asleep_st);
            awake  <= (state_d == rf_pg_pkg::awake);
        end
    end

endmodule

// File: hw/rf_pg_pkg.sv
// Power-gated register file shared definitions
// Geometry, switch chain depth and sequencer states

package rf_pg_pkg;

    // -----------------------------------------------
    // Array geometry
    // -----------------------------------------------

    // Number of words in the register file
    localparam int unsigned rf_depth = 16;

    // Address width covering every entry
    localparam int unsigned rf_addr_w = 4;

    // Word width seen by the logic that uses the register file
    localparam int unsigned rf_data_w = 45;

    // The physical macro carries one spare bit above the logical word
    localparam int unsigned rf_phys_w = rf_data_w + 1;

    // -----------------------------------------------
    // Power switch chain
    // -----------------------------------------------

    // Each switch segment delays the enable by one rclk cycle
    // The far end of the chain tells the sequencer that all segments switched
    localparam int unsigned pg_chain_len = 4;

    // -----------------------------------------------
    // Sequencer states
    // -----------------------------------------------

    // The array is powered and usable only in awake
    // Every other state keeps isolation raised
    // Only powering_off and asleep_st hold the switch enable high
    typedef enum logic [2:0] {
        awake        = 3'd0,
        isolating    = 3'd1,
        powering_off = 3'd2,
        asleep_st    = 3'd3,
        powering_on  = 3'd4
    } pg_state_t;

endpackage

// File: hw/rf_pg_subsystem.sv
// Power-gated register file subsystem
// Sequencer plus logical register file

module rf_pg_subsystem (
     input  logic                              wclk
    ,input  logic                              we
    ,input  logic [rf_pg_pkg::rf_addr_w-1:0]   waddr
    ,input  logic [rf_pg_pkg::rf_data_w-1:0]   wdata

    ,input  logic                              rclk
    ,input  logic                              re
    ,input  logic [rf_pg_pkg::rf_addr_w-1:0]   raddr
    ,output logic [rf_pg_pkg::rf_data_w-1:0]   rdata

    ,input  logic                              rst

    ,input  logic                              sleep_req

    ,output logic                              mem_ready
    ,output logic                              asleep
);

    logic pgcb_isol_en;
    logic pwr_enable_b_in;
    logic pwr_enable_b_out;
    logic ctrl_awake;
    logic rst_done;

    // Usable only once out of reset and fully powered with isolation down
    assign mem_ready = ctrl_awake && rst_done;

    rf_pg_ctrl rf_pg_ctrl_inst (
         .rclk              (rclk)
        ,.rst               (rst)
        ,.sleep_req         (sleep_req)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.pgcb_isol_en      (pgcb_isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.asleep            (asleep)
        ,.awake             (ctrl_awake)
        // State is only watched by the bound assertions
        ,.state             ()
    );

    rf_pg_16x45 rf_pg_16x45_inst (
         .wclk              (wclk)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)
        ,.rclk              (rclk)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)
        ,.rst               (rst)
        ,.pgcb_isol_en      (pgcb_isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.rst_done          (rst_done)
    );

endmodule

// File: project.f
hw/rf_pg_pkg.sv
hw/rf_pg_array.sv
hw/rf_pg_16x45.sv
hw/rf_pg_ctrl.sv
hw/rf_pg_subsystem.sv
dv/rf_pg_subsystem_sva.sv
dv/rf_pg_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register file regression with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module rf_pg_subsystem_tb \
    -f project.f -o rf_pg_sim \
    && ./obj_dir/rf_pg_sim > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q "^Regression passed$" sim.log 2>/dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
